/* src/dc302_data_pkg.sv */
/*
 * DC302 data chip, datapath definitions.
 * Word and register-select widths, flag word and ALU result types.
 */

package dc302_data_pkg;

   localparam int word_w    = 16;   // datapath width
   localparam int reg_count = 16;   // register file depth
   localparam int reg_sel_w = 4;    // register select width

   typedef logic [word_w-1:0]    word_t;
   typedef logic [reg_sel_w-1:0] reg_sel_t;

   // processor status flags, n in the top bit
   typedef struct packed
   {
      logic n;    // negative
      logic z;    // zero
      logic v;    // signed overflow
      logic c;    // carry or borrow
   } flags_t;

   typedef struct packed
   {
      word_t result;     // before the byte swap
      logic  carry;      // carry, borrow or shifted-out bit
      logic  overflow;   // signed overflow of the function
   } alu_out_t;

endpackage

/* src/dc302_micro_pkg.sv */
/*
 * DC302 data chip, microinstruction definitions.
 * Function codes, both field layouts of the micro word, latched control.
 */

package dc302_micro_pkg;

   localparam logic form_reg   = 1'b1;   // m[15] of the register form
   localparam int   br_sel_hi  = 10;     // branch condition select, m[10:8]
   localparam int   br_sel_lo  = 8;

   typedef enum logic [2:0]
   {
      mov    = 3'd0,
      add    = 3'd1,
      sub    = 3'd2,
      and_op = 3'd3,
      bic    = 3'd4,
      bis    = 3'd5,
      xor_op = 3'd6,
      asr    = 3'd7
   } alu_func_t;

   typedef struct packed
   {
      logic                     form;      // 1 here
      alu_func_t                func;
      logic                     bus_in;    // result from input bus
      logic                     swap;      // byte swap on write
      logic                     flag_wr;
      logic                     cin;       // add takes the stored carry
      dc302_data_pkg::reg_sel_t sb;
      dc302_data_pkg::reg_sel_t sa;
   } micro_reg_t;

   typedef struct packed
   {
      logic                     form;      // 0 here
      alu_func_t                func;
      logic [3:0]               k_lo;      // constant low nibble
      logic [3:0]               k_hi;      // constant high nibble
      dc302_data_pkg::reg_sel_t sa;
   } micro_const_t;

   // the micro word reads two ways, chosen by the form bit
   typedef union packed
   {
      micro_reg_t   r;
      micro_const_t k;
   } micro_word_t;

   typedef struct packed
   {
      alu_func_t func;
      logic      bus_in;
      logic      swap;
      logic      flag_wr;
      logic      cin;
   } micro_ctrl_t;

endpackage

/* src/micro_decoder.sv */
/*
 * Microinstruction field decoder.
 * Register selects and constant are combinational, control is latched at pin_mce_p.
 */

module micro_decoder
(
   input  logic                         pin_clk,
   input  logic                         arst_n,
   input  logic                         pin_mce_p,
   input  dc302_micro_pkg::micro_word_t m,
   output dc302_data_pkg::reg_sel_t     sa,
   output dc302_data_pkg::reg_sel_t     sb,
   output logic                         b_const,
   output dc302_data_pkg::word_t        const_word,
   output dc302_micro_pkg::micro_ctrl_t ctrl
);

   logic                         is_const;
   dc302_micro_pkg::micro_ctrl_t ctrl_nxt;

   assign is_const   = (m.r.form != dc302_micro_pkg::form_reg);
   assign sa         = m.r.sa;                          // same place in both forms
   assign sb         = m.r.sb;                          // don't care for constants
   assign b_const    = is_const;
   assign const_word = {8'h00, m.k.k_hi, m.k.k_lo};     // nibbles arrive swapped

   always_comb
   begin
      if (is_const)
      begin
         ctrl_nxt.func    = m.k.func;
         ctrl_nxt.bus_in  = 1'b0;
         ctrl_nxt.swap    = 1'b0;
         ctrl_nxt.flag_wr = 1'b1;                       // constant ops always set flags
         ctrl_nxt.cin     = 1'b0;
      end
      else
      begin
         ctrl_nxt.func    = m.r.func;
         ctrl_nxt.bus_in  = m.r.bus_in;
         ctrl_nxt.swap    = m.r.swap;
         ctrl_nxt.flag_wr = m.r.flag_wr;
         ctrl_nxt.cin     = m.r.cin;
      end
   end

   // held for the write stage after pin_m moves on
   always_ff @(posedge pin_clk or negedge arst_n)
   begin
      if (!arst_n)
         ctrl <= '0;
      else if (pin_mce_p)
         ctrl <= ctrl_nxt;
   end

endmodule

/* src/register_file.sv */
/*
 * Sixteen-word register file.
 * Port A reads and writes, port B reads only, write at pin_mce_n.
 */

module register_file
(
   input  logic                     pin_clk,
   input  logic                     arst_n,
   input  logic                     pin_mce_n,
   input  dc302_data_pkg::reg_sel_t sa,
   input  dc302_data_pkg::reg_sel_t sb,
   input  dc302_data_pkg::word_t    wd,
   output dc302_data_pkg::word_t    pa,
   output dc302_data_pkg::word_t    pb
);

   dc302_data_pkg::word_t regs [dc302_data_pkg::reg_count];

   assign pa = regs[sa];   // combinational read ports
   assign pb = regs[sb];

   always_ff @(posedge pin_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < dc302_data_pkg::reg_count; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (pin_mce_n)
      begin
         regs[sa] <= wd;   // sa still held from pin_m
      end
   end

endmodule

/* src/operand_latch.sv */
/*
 * A and B operand registers, loaded at pin_mce_p.
 * B takes either register port B or the microinstruction constant.
 */

module operand_latch
(
   input  logic                  pin_clk,
   input  logic                  arst_n,
   input  logic                  pin_mce_p,
   input  dc302_data_pkg::word_t pa,
   input  dc302_data_pkg::word_t pb,
   input  logic                  b_const,
   input  dc302_data_pkg::word_t const_word,
   output dc302_data_pkg::word_t a,
   output dc302_data_pkg::word_t b
);

   always_ff @(posedge pin_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         a <= '0;
         b <= '0;
      end
      else if (pin_mce_p)
      begin
         a <= pa;
         b <= b_const ? const_word : pb;   // constant form overrides port B
      end
   end

endmodule

/* src/function_unit.sv */
/*
 * ALU with nibble look-ahead carry, input bus select and byte swap.
 * Purely combinational between the operand latch and write-back.
 */

module function_unit
(
   input  dc302_micro_pkg::micro_ctrl_t ctrl,
   input  dc302_data_pkg::word_t        a,
   input  dc302_data_pkg::word_t        b,
   input  logic                         cin_flag,
   input  dc302_data_pkg::word_t        adi,
   output dc302_data_pkg::alu_out_t     alu,
   output dc302_data_pkg::word_t        wd
);

   dc302_data_pkg::word_t g;     // carry generate
   dc302_data_pkg::word_t p;     // propagate, the plain result for logic ops
   logic                  c0;    // carry into bit 0
   logic [16:0]           c;     // carry into each bit, c[16] is carry out
   dc302_data_pkg::word_t res;

   always_comb
   begin
      g  = '0;
      c0 = 1'b0;
      case (ctrl.func)
         dc302_micro_pkg::add:
         begin
            g  = a & b;
            p  = a ^ b;
            c0 = ctrl.cin & cin_flag;
         end
         dc302_micro_pkg::sub:
         begin
            g  = a & ~b;                  // a + ~b + 1
            p  = a ^ ~b;
            c0 = 1'b1;
         end
         dc302_micro_pkg::and_op: p = a & b;
         dc302_micro_pkg::bic:    p = a & ~b;
         dc302_micro_pkg::bis:    p = a | b;
         dc302_micro_pkg::xor_op: p = a ^ b;
         dc302_micro_pkg::asr:    p = {b[15], b[15:1]};
         default:                 p = b;  // mov
      endcase
   end

   // carries resolved four bits at a time
   always_comb
   begin
      c[0] = c0;
      for (int nb = 0; nb < dc302_data_pkg::word_w; nb += 4)
      begin
         c[nb+1] = g[nb] | p[nb] & c[nb];
         c[nb+2] = g[nb+1] | p[nb+1] & g[nb] | p[nb+1] & p[nb] & c[nb];
         c[nb+3] = g[nb+2] | p[nb+2] & g[nb+1] | p[nb+2] & p[nb+1] & g[nb]
                 | p[nb+2] & p[nb+1] & p[nb] & c[nb];
         c[nb+4] = g[nb+3] | p[nb+3] & g[nb+2] | p[nb+3] & p[nb+2] & g[nb+1]
                 | p[nb+3] & p[nb+2] & p[nb+1] & g[nb]
                 | p[nb+3] & p[nb+2] & p[nb+1] & p[nb] & c[nb];
      end
   end

   assign res = ctrl.bus_in ? adi : (p ^ c[15:0]);

   always_comb
   begin
      alu.result   = res;
      alu.carry    = c[16];                   // zero for logic ops
      alu.overflow = c[15] ^ c[16];
      if (ctrl.func == dc302_micro_pkg::sub)
         alu.carry = ~c[16];                  // borrow
      else if (ctrl.func == dc302_micro_pkg::asr)
      begin
         alu.carry    = b[0];                 // bit shifted out
         alu.overflow = res[15] ^ b[0];
      end
   end

   assign wd = ctrl.swap ? {res[7:0], res[15:8]} : res;

endmodule

/* src/status_register.sv */
/*
 * N, Z, V, C flag update and storage, plus the microbranch condition.
 * Flags load at pin_mce_n when the latched control asks for it.
 */

module status_register
(
   input  logic                         pin_clk,
   input  logic                         arst_n,
   input  logic                         pin_mce_n,
   input  dc302_micro_pkg::micro_ctrl_t ctrl,
   input  dc302_data_pkg::alu_out_t     alu,
   input  dc302_micro_pkg::micro_word_t m,
   output dc302_data_pkg::flags_t       flags,
   output logic                         mbra
);

   dc302_data_pkg::flags_t flags_nxt;
   logic [2:0]             br_sel;
   logic                   cond;

   always_comb
   begin
      flags_nxt.n = alu.result[dc302_data_pkg::word_w-1];
      flags_nxt.z = (alu.result == '0);
      flags_nxt.v = 1'b0;
      flags_nxt.c = flags.c;                  // kept by logic, mov and bus input
      if (!ctrl.bus_in)
      begin
         case (ctrl.func)
            dc302_micro_pkg::add, dc302_micro_pkg::sub, dc302_micro_pkg::asr:
            begin
               flags_nxt.v = alu.overflow;
               flags_nxt.c = alu.carry;
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge pin_clk or negedge arst_n)
   begin
      if (!arst_n)
         flags <= '0;
      else if (pin_mce_n && ctrl.flag_wr)
         flags <= flags_nxt;
   end

   // condition from live pin_m over the stored flags
   assign br_sel = m[dc302_micro_pkg::br_sel_hi:dc302_micro_pkg::br_sel_lo];

   always_comb
   begin
      case (br_sel[1:0])
         2'd0:    cond = flags.n;
         2'd1:    cond = flags.z;
         2'd2:    cond = flags.c;
         default: cond = flags.v;
      endcase
   end

   assign mbra = cond ^ br_sel[2];            // upper half inverts

endmodule

/* src/dc302.sv */
/*
 * DC302 data chip, reduced microcoded 16-bit datapath.
 * Two-phase operation on the master strobes pin_mce_p and pin_mce_n.
 */

module dc302
(
   input  logic                         pin_clk,
   input  logic                         arst_n,
   input  logic                         pin_mce_p,   // operand phase
   input  logic                         pin_mce_n,   // write-back phase
   input  dc302_micro_pkg::micro_word_t pin_m,
   input  dc302_data_pkg::word_t        pin_adi,
   output dc302_data_pkg::word_t        pin_ado,     // latched A operand
   output dc302_data_pkg::flags_t       pin_psw,
   output logic                         pin_mbra
);

   dc302_data_pkg::reg_sel_t     sa;
   dc302_data_pkg::reg_sel_t     sb;
   logic                         b_const;
   dc302_data_pkg::word_t        const_word;
   dc302_micro_pkg::micro_ctrl_t ctrl;
   dc302_data_pkg::word_t        pa;
   dc302_data_pkg::word_t        pb;
   dc302_data_pkg::word_t        b;
   dc302_data_pkg::alu_out_t     alu;
   dc302_data_pkg::word_t        wd;

   micro_decoder u_decoder
   (
      .pin_clk    (pin_clk),
      .arst_n     (arst_n),
      .pin_mce_p  (pin_mce_p),
      .m          (pin_m),
      .sa         (sa),
      .sb         (sb),
      .b_const    (b_const),
      .const_word (const_word),
      .ctrl       (ctrl)
   );

   register_file u_regs
   (
      .pin_clk   (pin_clk),
      .arst_n    (arst_n),
      .pin_mce_n (pin_mce_n),
      .sa        (sa),
      .sb        (sb),
      .wd        (wd),
      .pa        (pa),
      .pb        (pb)
   );

   operand_latch u_operands
   (
      .pin_clk    (pin_clk),
      .arst_n     (arst_n),
      .pin_mce_p  (pin_mce_p),
      .pa         (pa),
      .pb         (pb),
      .b_const    (b_const),
      .const_word (const_word),
      .a          (pin_ado),
      .b          (b)
   );

   function_unit u_alu
   (
      .ctrl     (ctrl),
      .a        (pin_ado),
      .b        (b),
      .cin_flag (pin_psw.c),
      .adi      (pin_adi),
      .alu      (alu),
      .wd       (wd)
   );

   status_register u_status
   (
      .pin_clk   (pin_clk),
      .arst_n    (arst_n),
      .pin_mce_n (pin_mce_n),
      .ctrl      (ctrl),
      .alu       (alu),
      .m         (pin_m),
      .flags     (pin_psw),
      .mbra      (pin_mbra)
   );

endmodule

/* verif/tb_clock.sv */
/*
 * Testbench clock and reset source.
 * Period of 10, reset held low for the first 4 cycles.
 */

module tb_clock
(
   output logic pin_clk,
   output logic arst_n
);

   initial
   begin
      pin_clk = 1'b0;
      forever #5 pin_clk = ~pin_clk;
   end

   initial
   begin
      arst_n = 1'b0;
      repeat (4) @(posedge pin_clk);
      arst_n <= 1'b1;   // released on a rising edge
   end

endmodule

/* verif/tb_dc302.sv */
/*
 * Testbench for the DC302 datapath.
 * Runs microinstructions against a reference model, assertions compare.
 */

module tb_dc302;

   logic        pin_clk;
   logic        arst_n;
   logic        pin_mce_p;
   logic        pin_mce_n;
   logic [15:0] pin_m;
   logic [15:0] pin_adi;
   logic [15:0] pin_ado;
   logic [3:0]  pin_psw;                 // n z v c
   logic        pin_mbra;

   logic [15:0] model_regs [16];
   logic [3:0]  exp_flags;
   logic [15:0] exp_a;
   logic        exp_mbra;

   tb_clock u_clock
   (
      .pin_clk (pin_clk),
      .arst_n  (arst_n)
   );

   dc302 UUT
   (
      .pin_clk   (pin_clk),
      .arst_n    (arst_n),
      .pin_mce_p (pin_mce_p),
      .pin_mce_n (pin_mce_n),
      .pin_m     (pin_m),
      .pin_adi   (pin_adi),
      .pin_ado   (pin_ado),
      .pin_psw   (pin_psw),
      .pin_mbra  (pin_mbra)
   );

   // condition table over n z v c
   function automatic logic branch_cond(input logic [2:0] sel, input logic [3:0] f);
      logic cond;
      case (sel)
         3'd0: cond = f[3];
         3'd1: cond = f[2];
         3'd2: cond = f[0];
         3'd3: cond = f[1];
         3'd4: cond = ~f[3];
         3'd5: cond = ~f[2];
         3'd6: cond = ~f[0];
         3'd7: cond = ~f[1];
      endcase
      return cond;
   endfunction

   function automatic logic [15:0] reg_word(input logic [2:0] func, input logic bus_in,
                                            input logic swap, input logic flag_wr,
                                            input logic cin, input logic [3:0] sb,
                                            input logic [3:0] sa);
      return {1'b1, func, bus_in, swap, flag_wr, cin, sb, sa};
   endfunction

   function automatic logic [15:0] const_word(input logic [2:0] func, input logic [7:0] k,
                                              input logic [3:0] sa);
      return {1'b0, func, k[3:0], k[7:4], sa};   // low nibble sits higher
   endfunction

   task automatic report_mismatch(input string name, input logic [15:0] expv,
                                  input logic [15:0] got);
      $display("mismatch at time %0t: %s expected %h, actual %h", $time, name, expv, got);
      $display("Verification failed");
      $fatal(1, "stopped at first error");
   endtask

   always_comb exp_mbra = branch_cond(pin_m[10:8], exp_flags);

   a_ado: assert property (@(posedge pin_clk) disable iff (!arst_n)
                           pin_mce_p |=> pin_ado == exp_a)
      else report_mismatch("pin_ado", $sampled(exp_a), $sampled(pin_ado));

   a_psw: assert property (@(posedge pin_clk) disable iff (!arst_n)
                           pin_mce_n |=> pin_psw == exp_flags)
      else report_mismatch("pin_psw", {12'h000, $sampled(exp_flags)},
                           {12'h000, $sampled(pin_psw)});

   a_mbra: assert property (@(posedge pin_clk) disable iff (!arst_n)
                            pin_mbra == exp_mbra)
      else report_mismatch("pin_mbra", {15'h0000, $sampled(exp_mbra)},
                           {15'h0000, $sampled(pin_mbra)});

   // walks m[10:8] through all eight conditions, no strobes
   task automatic sweep_branch(input logic [15:0] w);
      for (int k = 0; k < 8; k++)
      begin
         @(posedge pin_clk);
         pin_m <= {w[15:11], 3'(k), w[7:0]};
      end
   endtask

   task automatic run_op(input logic [15:0] w, input logic [15:0] adi);
      logic [3:0]  sa;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] r;
      logic [16:0] sum;
      logic [3:0]  nf;
      sa = w[3:0];
      a  = model_regs[sa];
      b  = w[15] ? model_regs[w[7:4]] : {8'h00, w[7:4], w[11:8]};
      nf = exp_flags;
      nf[1] = 1'b0;                      // v clear unless arithmetic
      case (w[14:12])
         dc302_micro_pkg::add:
         begin
            sum   = {1'b0, a} + {1'b0, b} + {16'h0000, w[15] & w[8] & exp_flags[0]};
            r     = sum[15:0];
            nf[0] = sum[16];
            nf[1] = (a[15] == b[15]) && (r[15] != a[15]);
         end
         dc302_micro_pkg::sub:
         begin
            r     = a - b;
            nf[0] = (a < b);             // unsigned borrow
            nf[1] = (a[15] != b[15]) && (r[15] != a[15]);
         end
         dc302_micro_pkg::and_op: r = a & b;
         dc302_micro_pkg::bic:    r = a & ~b;
         dc302_micro_pkg::bis:    r = a | b;
         dc302_micro_pkg::xor_op: r = a ^ b;
         dc302_micro_pkg::asr:
         begin
            r     = {b[15], b[15:1]};
            nf[0] = b[0];
            nf[1] = r[15] ^ b[0];
         end
         default: r = b;
      endcase
      if (w[15] && w[11])
      begin
         r     = adi;                    // bus input
         nf[1] = 1'b0;
         nf[0] = exp_flags[0];
      end
      nf[3] = r[15];
      nf[2] = (r == 16'h0000);

      @(posedge pin_clk);
      pin_m     <= w;
      pin_adi   <= adi;
      pin_mce_p <= 1'b1;
      exp_a = a;
      @(posedge pin_clk);
      pin_mce_p <= 1'b0;
      @(posedge pin_clk);
      pin_mce_n <= 1'b1;
      @(posedge pin_clk);
      pin_mce_n <= 1'b0;
      model_regs[sa] = (w[15] && w[10]) ? {r[7:0], r[15:8]} : r;
      if (!w[15] || w[9])
         exp_flags = nf;
      sweep_branch(w);
   endtask

   task automatic load_reg(input int r, input logic [15:0] value);
      run_op(reg_word(dc302_micro_pkg::mov, 1'b1, 1'b0, 1'b1, 1'b0, 4'h0, 4'(r)), value);
   endtask

   task automatic read_reg(input int r);
      run_op(reg_word(dc302_micro_pkg::bis, 1'b0, 1'b0, 1'b0, 1'b0, 4'(r), 4'(r)), 16'h0000);
   endtask

   task automatic random_logic_op(input int count);
      logic [2:0] f;
      for (int i = 0; i < count; i++)
      begin
         case ($urandom_range(4, 0))
            0:       f = dc302_micro_pkg::and_op;
            1:       f = dc302_micro_pkg::bic;
            2:       f = dc302_micro_pkg::bis;
            3:       f = dc302_micro_pkg::xor_op;
            default: f = dc302_micro_pkg::mov;
         endcase
         run_op(reg_word(f, 1'b0, 1'b0, 1'($urandom()), 1'b0, 4'($urandom()),
                         4'($urandom())), 16'h0000);
      end
   endtask

   initial
   begin
      int wait_cnt;
      logic [2:0] f;
      void'($urandom(12));
      pin_mce_p = 1'b0;
      pin_mce_n = 1'b0;
      pin_m     = 16'h0000;
      pin_adi   = 16'h0000;
      exp_flags = 4'h0;
      exp_a     = 16'h0000;
      for (int i = 0; i < 16; i++)
         model_regs[i] = 16'h0000;

      wait_cnt = 0;
      while (arst_n !== 1'b1 && wait_cnt < 50)
      begin
         @(posedge pin_clk);
         wait_cnt++;
      end
      if (arst_n !== 1'b1)
      begin
         $display("timeout while waiting for the reset to be released");
         $display("Verification failed");
         $fatal(1, "reset wait expired");
      end

      for (int i = 0; i < 16; i++)
         read_reg(i);                    // all zero after reset

      for (int s = 0; s < 2; s++)
      begin
         for (int i = 0; i < 16; i++)
            run_op(reg_word(dc302_micro_pkg::mov, 1'b1, 1'(s), 1'b1, 1'b0, 4'h0, 4'(i)),
                   16'($urandom()));
         for (int i = 0; i < 16; i++)
            read_reg(i);
      end

      // arithmetic edges around the sign boundary and wrap
      load_reg(1, 16'h7fff);
      run_op(const_word(dc302_micro_pkg::add, 8'h01, 4'd1), 16'h0000);
      load_reg(2, 16'h8000);
      run_op(const_word(dc302_micro_pkg::sub, 8'h01, 4'd2), 16'h0000);
      load_reg(3, 16'hffff);
      run_op(const_word(dc302_micro_pkg::add, 8'h01, 4'd3), 16'h0000);
      load_reg(4, 16'h0000);
      run_op(const_word(dc302_micro_pkg::sub, 8'h01, 4'd4), 16'h0000);
      load_reg(5, 16'h7fff);
      run_op(const_word(dc302_micro_pkg::sub, 8'hff, 4'd5), 16'h0000);
      for (int i = 0; i < 24; i++)
      begin
         f = ($urandom_range(1, 0) == 0) ? dc302_micro_pkg::add : dc302_micro_pkg::sub;
         run_op(const_word(f, 8'($urandom()), 4'($urandom())), 16'h0000);
      end

      // logic ops with c and v preset to one, then with c clear and v set
      load_reg(6, 16'h8000);
      run_op(reg_word(dc302_micro_pkg::add, 1'b0, 1'b0, 1'b1, 1'b0, 4'd6, 4'd6), 16'h0000);
      random_logic_op(15);
      load_reg(6, 16'h8000);
      run_op(const_word(dc302_micro_pkg::sub, 8'h01, 4'd6), 16'h0000);
      random_logic_op(15);

      load_reg(8, 16'h8001);
      load_reg(9, 16'h4000);
      load_reg(10, 16'hffff);
      load_reg(11, 16'h0001);
      for (int i = 8; i < 12; i++)
         run_op(reg_word(dc302_micro_pkg::asr, 1'b0, 1'b0, 1'b1, 1'b0, 4'(i), 4'(i)),
                16'h0000);

      // add through the stored carry, set and then clear
      load_reg(13, 16'($urandom()));
      load_reg(14, 16'($urandom()));
      load_reg(12, 16'hffff);
      run_op(const_word(dc302_micro_pkg::add, 8'h01, 4'd12), 16'h0000);
      run_op(reg_word(dc302_micro_pkg::add, 1'b0, 1'b0, 1'b1, 1'b1, 4'd14, 4'd13), 16'h0000);
      run_op(const_word(dc302_micro_pkg::sub, 8'h00, 4'd12), 16'h0000);
      run_op(reg_word(dc302_micro_pkg::add, 1'b0, 1'b0, 1'b1, 1'b1, 4'd14, 4'd13), 16'h0000);

      repeat (2) @(posedge pin_clk);
      $display("Verification passed");
      $finish;
   end

endmodule

/* sources.f */
src/dc302_data_pkg.sv
src/dc302_micro_pkg.sv
src/micro_decoder.sv
src/register_file.sv
src/operand_latch.sv
src/function_unit.sv
src/status_register.sv
src/dc302.sv
verif/tb_clock.sv
verif/tb_dc302.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tb_dc302
FLIST = sources.f
LOG   = sim.log
OBJ   = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
